/* bus_pkg.sv */
`default_nettype none

// shared definitions for the two-master split-transaction address bus
package bus_pkg;

	// width of a transfer address on the address bus
	localparam int ADDR_W = 16;

	// address arbiter states
	// the digit names the master that owns the bus now or owned it last
	// the idle digit is what lets the arbiter alternate under contention
	typedef enum logic [2:0] {
		arb_idle1,
		arb_idle2,
		arb_granted1,
		arb_granted1_aack,
		arb_granted2,
		arb_granted2_aack
	} arb_state_t;

	// owner of an address tenure, and so of the data tenure that follows it
	typedef enum logic {
		owner_m1,
		owner_m2
	} owner_t;

endpackage

`default_nettype wire

/* addr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// address bus arbiter for two masters
// grants alternate under contention, the grant stays up through the
// acknowledge cycle so the owner can park, and no grant is made while a
// retry is on the bus
module addr_arbiter
	import bus_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic br1_n,
	input  logic br2_n,
	input  logic ts_n,
	input  logic aack_n,
	input  logic artry_n,
	output logic bg1_n,
	output logic bg2_n
);

	arb_state_t state;
	arb_state_t state_next;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= arb_idle1;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			arb_idle1, arb_idle2: begin
				if (!artry_n) begin
					// the retried master must get another chance, so hold off
					state_next = state;
				end else if (!ts_n) begin
					// a transfer started on a parked grant from the acknowledge
					// cycle, so track the tenure of the last owner
					state_next = (state == arb_idle1) ? arb_granted1 : arb_granted2;
				end else if (!br1_n && br2_n) begin
					state_next = arb_granted1;
				end else if (!br2_n && br1_n) begin
					state_next = arb_granted2;
				end else if (br1_n && br2_n) begin
					state_next = state;
				end else begin
					// both request, so the one that did not own the bus last wins
					state_next = (state == arb_idle1) ? arb_granted2 : arb_granted1;
				end
			end
			arb_granted1: begin
				if (!aack_n) begin
					state_next = arb_granted1_aack;
				end
			end
			// one cycle of grant after the acknowledge covers the retry window
			arb_granted1_aack: begin
				state_next = arb_idle1;
			end
			arb_granted2: begin
				if (!aack_n) begin
					state_next = arb_granted2_aack;
				end
			end
			arb_granted2_aack: begin
				state_next = arb_idle2;
			end
			default: begin
				state_next = arb_idle1;
			end
		endcase
	end

	// grants decode straight from the state, so they follow the deciding edge
	assign bg1_n = !(state == arb_granted1 || state == arb_granted1_aack);
	assign bg2_n = !(state == arb_granted2 || state == arb_granted2_aack);

endmodule

`default_nettype wire

/* bus_master.sv */
`timescale 1ns/1ps
`default_nettype none

// bus master model
// one command becomes a request, a one-cycle transfer start and an address
// tenure that ends either in a retry or in a completion pulse
module bus_master
	import bus_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              cmd_valid,
	input  logic [ADDR_W-1:0] cmd_addr,
	input  logic              bg_n,
	input  logic              aack_n,
	input  logic              artry_n,
	output logic              br_n,
	output logic              ts_n,
	output logic [ADDR_W-1:0] addr,
	output logic              busy,
	output logic              done,
	output logic [ADDR_W-1:0] done_addr
);

	typedef enum logic [2:0] {
		m_idle,
		m_request,
		m_address,
		m_wait_ack,
		m_retry_win
	} master_state_t;

	master_state_t state;
	logic [ADDR_W-1:0] addr_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= m_idle;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				// commands are only taken here, anything while busy is dropped
				m_idle: begin
					if (cmd_valid) begin
						state <= m_request;
					end
				end
				m_request: begin
					if (!bg_n) begin
						state <= m_address;
					end
				end
				// the transfer start is exactly one cycle long
				m_address: begin
					state <= m_wait_ack;
				end
				m_wait_ack: begin
					if (!aack_n) begin
						state <= m_retry_win;
					end
				end
				// the cycle after aack carries the retry decision
				m_retry_win: begin
					if (!artry_n) begin
						state <= m_request;
					end else begin
						state <= m_idle;
						done <= 1'b1;
					end
				end
				default: begin
					state <= m_idle;
				end
			endcase
		end
	end

	// the command address is kept across retries until the next command
	always_ff @(posedge clk) begin
		if (state == m_idle && cmd_valid) begin
			addr_q <= cmd_addr;
		end
	end

	assign br_n = (state != m_request);
	assign ts_n = (state != m_address);
	assign busy = (state != m_idle);
	// zero outside the tenure so the top level can OR both masters together
	assign addr = (state == m_address || state == m_wait_ack) ? addr_q : '0;
	assign done_addr = addr_q;

endmodule

`default_nettype wire

/* snoop_responder.sv */
`timescale 1ns/1ps
`default_nettype none

// snoop responder model
// acknowledges every transfer start after a fixed delay and retries the
// transfer when its address matches the locked address
module snoop_responder
	import bus_pkg::*;
#(
	parameter int ACK_DELAY = 2
)(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              ts_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic              lock_valid,
	input  logic [ADDR_W-1:0] lock_addr,
	output logic              aack_n,
	output logic              artry_n
);

	localparam int CNT_W = (ACK_DELAY > 1) ? $clog2(ACK_DELAY) : 1;

	logic             active;
	logic [CNT_W-1:0] cnt;
	logic             artry_q;
	logic [ADDR_W-1:0] addr_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			cnt <= '0;
			artry_q <= 1'b0;
		end else begin
			artry_q <= 1'b0;
			if (!active && !artry_q) begin
				// a new start is only taken once the retry window has passed
				if (!ts_n) begin
					active <= 1'b1;
					cnt <= CNT_W'(ACK_DELAY - 1);
				end
			end else if (active) begin
				if (cnt == '0) begin
					// end of the aack cycle, the lock check lands in the next one
					active <= 1'b0;
					artry_q <= lock_valid && (addr_q == lock_addr);
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!active && !artry_q && !ts_n) begin
			addr_q <= addr;
		end
	end

	// aack is low for the single cycle in which the count has run out
	assign aack_n = !(active && cnt == '0);
	assign artry_n = !artry_q;

endmodule

`default_nettype wire

/* data_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// data bus arbiter
// address tenures that complete without retry queue up here in order, and
// each gets the data bus for a fixed number of beats
module data_arbiter
	import bus_pkg::*;
#(
	parameter int DATA_BEATS = 4
)(
	input  logic clk,
	input  logic arst_n,
	input  logic aack_n,
	input  logic artry_n,
	input  logic bg1_n,
	output logic dbg1_n,
	output logic dbg2_n
);

	localparam int BEAT_W = (DATA_BEATS > 1) ? $clog2(DATA_BEATS) : 1;

	logic              pend_valid;
	owner_t            pend_owner;
	owner_t            queue [0:1];
	logic [1:0]        q_count;
	logic              active;
	owner_t            gnt_owner;
	logic [BEAT_W-1:0] beat;
	logic              push;
	logic              start;
	logic              pop;
	logic              enq;
	logic [1:0]        count_after_pop;
	owner_t            start_owner;

	always_comb begin
		// a tenure counts only if no retry follows its acknowledge
		push = pend_valid && artry_n;
		start = !active && (q_count != 2'd0 || push);
		pop = start && (q_count != 2'd0);
		count_after_pop = q_count - {1'b0, pop};
		// with an empty queue a fresh push goes straight to the grant
		enq = push && !(start && !pop) && (count_after_pop != 2'd2);
		start_owner = pop ? queue[0] : pend_owner;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_valid <= 1'b0;
			pend_owner <= owner_m1;
			q_count <= 2'd0;
			active <= 1'b0;
			gnt_owner <= owner_m1;
			beat <= '0;
		end else begin
			// during aack the owner still holds its address grant
			pend_valid <= !aack_n;
			if (!aack_n) begin
				pend_owner <= bg1_n ? owner_m2 : owner_m1;
			end
			q_count <= count_after_pop + {1'b0, enq};
			if (start) begin
				active <= 1'b1;
				gnt_owner <= start_owner;
				beat <= BEAT_W'(DATA_BEATS - 1);
			end else if (active) begin
				// one idle cycle between grants keeps each grant distinct
				if (beat == '0) begin
					active <= 1'b0;
				end else begin
					beat <= beat - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			queue[0] <= queue[1];
		end
		if (enq) begin
			queue[count_after_pop[0]] <= pend_owner;
		end
	end

	assign dbg1_n = !(active && gnt_owner == owner_m1);
	assign dbg2_n = !(active && gnt_owner == owner_m2);

endmodule

`default_nettype wire

/* bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

// two masters on one address bus with its arbiter, a snoop responder and
// the data bus arbiter that orders the data tenures
module bus_top
	import bus_pkg::*;
#(
	parameter int ACK_DELAY  = 2,
	parameter int DATA_BEATS = 4
)(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              cmd1_valid,
	input  logic [ADDR_W-1:0] cmd1_addr,
	input  logic              cmd2_valid,
	input  logic [ADDR_W-1:0] cmd2_addr,
	input  logic              lock_valid,
	input  logic [ADDR_W-1:0] lock_addr,
	output logic              bg1_n,
	output logic              bg2_n,
	output logic              dbg1_n,
	output logic              dbg2_n,
	output logic              busy1,
	output logic              busy2,
	output logic              done1,
	output logic [ADDR_W-1:0] done1_addr,
	output logic              done2,
	output logic [ADDR_W-1:0] done2_addr
);

	logic              br1_n;
	logic              br2_n;
	logic              ts1_n;
	logic              ts2_n;
	logic              ts_n;
	logic [ADDR_W-1:0] addr1;
	logic [ADDR_W-1:0] addr2;
	logic [ADDR_W-1:0] addr;
	logic              aack_n;
	logic              artry_n;

	// only the granted master drives a start or a nonzero address
	assign ts_n = ts1_n & ts2_n;
	assign addr = addr1 | addr2;

	bus_master u_master1 (
		.clk(clk), .arst_n(arst_n), .cmd_valid(cmd1_valid), .cmd_addr(cmd1_addr),
		.bg_n(bg1_n), .aack_n(aack_n), .artry_n(artry_n), .br_n(br1_n), .ts_n(ts1_n),
		.addr(addr1), .busy(busy1), .done(done1), .done_addr(done1_addr)
	);

	bus_master u_master2 (
		.clk(clk), .arst_n(arst_n), .cmd_valid(cmd2_valid), .cmd_addr(cmd2_addr),
		.bg_n(bg2_n), .aack_n(aack_n), .artry_n(artry_n), .br_n(br2_n), .ts_n(ts2_n),
		.addr(addr2), .busy(busy2), .done(done2), .done_addr(done2_addr)
	);

	addr_arbiter u_addr_arbiter (
		.clk(clk), .arst_n(arst_n), .br1_n(br1_n), .br2_n(br2_n), .ts_n(ts_n),
		.aack_n(aack_n), .artry_n(artry_n), .bg1_n(bg1_n), .bg2_n(bg2_n)
	);

	snoop_responder #(.ACK_DELAY(ACK_DELAY)) u_snoop_responder (
		.clk(clk), .arst_n(arst_n), .ts_n(ts_n), .addr(addr), .lock_valid(lock_valid),
		.lock_addr(lock_addr), .aack_n(aack_n), .artry_n(artry_n)
	);

	data_arbiter #(.DATA_BEATS(DATA_BEATS)) u_data_arbiter (
		.clk(clk), .arst_n(arst_n), .aack_n(aack_n), .artry_n(artry_n), .bg1_n(bg1_n),
		.dbg1_n(dbg1_n), .dbg2_n(dbg2_n)
	);

endmodule

`default_nettype wire

/* tb_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

// self-checking testbench for the two-master address bus
// a reference arbitration function predicts the completion order of directed rounds,
// queues of expected addresses and owners check every completion and every data grant
module tb_bus_top
	import bus_pkg::*;
();

	localparam int ACK_DELAY = 2;
	localparam int DATA_BEATS = 4;
	localparam int RANDOM_CMDS = 200;
	// upper bound on the commands of the directed tests
	localparam int DIRECTED_CMDS = 24;
	localparam int WATCHDOG_CYCLES =
		(RANDOM_CMDS + DIRECTED_CMDS) * (ACK_DELAY + DATA_BEATS + 8) + 2000;

	logic              clk;
	logic              arst_n;
	logic              cmd1_valid;
	logic [ADDR_W-1:0] cmd1_addr;
	logic              cmd2_valid;
	logic [ADDR_W-1:0] cmd2_addr;
	logic              lock_valid;
	logic [ADDR_W-1:0] lock_addr;
	logic              bg1_n;
	logic              bg2_n;
	logic              dbg1_n;
	logic              dbg2_n;
	logic              busy1;
	logic              busy2;
	logic              done1;
	logic [ADDR_W-1:0] done1_addr;
	logic              done2;
	logic [ADDR_W-1:0] done2_addr;

	// outstanding command addresses per master, oldest first
	logic [ADDR_W-1:0] exp_addr1 [$];
	logic [ADDR_W-1:0] exp_addr2 [$];
	// predicted completion owners of directed rounds, and completions waiting for data
	owner_t            order_q [$];
	owner_t            data_q [$];
	owner_t            last_owner;
	logic              prev_dbg [1:2];
	int                dbg_len [1:2];
	int                sent;
	int                lock_hold;
	int                gap;
	int                pick;
	integer            seed;
	logic [ADDR_W-1:0] rand_addr;

	bus_top #(.ACK_DELAY(ACK_DELAY), .DATA_BEATS(DATA_BEATS)) uut (
		.clk(clk), .arst_n(arst_n), .cmd1_valid(cmd1_valid), .cmd1_addr(cmd1_addr),
		.cmd2_valid(cmd2_valid), .cmd2_addr(cmd2_addr), .lock_valid(lock_valid),
		.lock_addr(lock_addr), .bg1_n(bg1_n), .bg2_n(bg2_n), .dbg1_n(dbg1_n),
		.dbg2_n(dbg2_n), .busy1(busy1), .busy2(busy2), .done1(done1),
		.done1_addr(done1_addr), .done2(done2), .done2_addr(done2_addr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// next owner of the address bus given the last owner and the pending requests
	function automatic owner_t expected_owner(input owner_t last, input logic req1,
		input logic req2);
		if (req1 && !req2) begin
			return owner_m1;
		end else if (req2 && !req1) begin
			return owner_m2;
		end else if (req1 && req2) begin
			// under contention the master that did not own the bus last wins
			return (last == owner_m1) ? owner_m2 : owner_m1;
		end
		return last;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// advance to just after the next rising edge and end any command pulse
	task automatic step();
		@(posedge clk);
		#1;
		cmd1_valid = 1'b0;
		cmd2_valid = 1'b0;
	endtask

	task automatic drive_cmd(input int m, input logic [ADDR_W-1:0] a);
		if (m == 1) begin
			cmd1_valid = 1'b1;
			cmd1_addr = a;
			exp_addr1.push_back(a);
		end else begin
			cmd2_valid = 1'b1;
			cmd2_addr = a;
			exp_addr2.push_back(a);
		end
	endtask

	task automatic wait_idle();
		while (busy1 || busy2 || exp_addr1.size() != 0 || exp_addr2.size() != 0) begin
			step();
		end
	endtask

	// one round of commands issued in the same cycle, with its completion order predicted
	task automatic run_round(input logic req1, input logic req2);
		owner_t first;
		owner_t second;
		first = expected_owner(last_owner, req1, req2);
		second = (first == owner_m1) ? owner_m2 : owner_m1;
		order_q.push_back(first);
		if (req1 && req2) begin
			order_q.push_back(second);
			last_owner = second;
		end else begin
			last_owner = first;
		end
		if (req1) begin
			drive_cmd(1, ADDR_W'($random(seed)));
		end
		if (req2) begin
			drive_cmd(2, ADDR_W'($random(seed)));
		end
		step();
		wait_idle();
	endtask

	task automatic check_done(input int m, input logic d, input logic [ADDR_W-1:0] d_addr,
		input logic b);
		logic [ADDR_W-1:0] want;
		owner_t            who;
		owner_t            head;
		who = (m == 1) ? owner_m1 : owner_m2;
		if (d) begin
			assert ((m == 1 ? exp_addr1.size() : exp_addr2.size()) != 0)
			else stop_with_error($sformatf("master %0d signalled done with nothing outstanding", m));
			if (m == 1) begin
				want = exp_addr1.pop_front();
			end else begin
				want = exp_addr2.pop_front();
			end
			assert (d_addr == want)
			else stop_with_error($sformatf("[FAIL] done%0d_addr expected 0x%h got 0x%h",
				m, want, d_addr));
			assert (!b)
			else stop_with_error($sformatf("[FAIL] busy%0d expected 0x0 got 0x%h", m, b));
			// a locked address has to keep retrying for as long as the lock holds
			assert (!(lock_valid && d_addr == lock_addr))
			else stop_with_error($sformatf("master %0d completed locked address 0x%h", m, d_addr));
			if (order_q.size() != 0) begin
				head = order_q.pop_front();
				assert (head == who)
				else stop_with_error($sformatf("[FAIL] completion owner expected 0x%h got 0x%h",
					head, who));
			end
			data_q.push_back(who);
		end
	endtask

	task automatic check_data_grant(input int m, input logic dbg);
		owner_t who;
		owner_t head;
		who = (m == 1) ? owner_m1 : owner_m2;
		if (!dbg && prev_dbg[m]) begin
			assert (data_q.size() != 0)
			else stop_with_error($sformatf("data grant to master %0d with no tenure waiting", m));
			head = data_q.pop_front();
			assert (head == who)
			else stop_with_error($sformatf("[FAIL] data grant owner expected 0x%h got 0x%h",
				head, who));
		end
		if (!dbg) begin
			dbg_len[m]++;
		end else if (!prev_dbg[m]) begin
			assert (dbg_len[m] == DATA_BEATS)
			else stop_with_error($sformatf("[FAIL] dbg%0d_n low cycles expected 0x%h got 0x%h",
				m, DATA_BEATS, dbg_len[m]));
			dbg_len[m] = 0;
		end
		prev_dbg[m] = dbg;
	endtask

	// outputs are settled by the falling edge, so every check samples there
	always @(negedge clk) begin
		if (!arst_n) begin
			assert (bg1_n && bg2_n && dbg1_n && dbg2_n)
			else stop_with_error("a grant is asserted while reset is held");
			assert (!busy1 && !busy2 && !done1 && !done2)
			else stop_with_error("busy or done is high while reset is held");
			prev_dbg[1] = 1'b1;
			prev_dbg[2] = 1'b1;
			dbg_len[1] = 0;
			dbg_len[2] = 0;
		end else begin
			assert (bg1_n || bg2_n) else stop_with_error("both address grants are low together");
			assert (dbg1_n || dbg2_n) else stop_with_error("both data grants are low together");
			// an address grant only ever goes to a master with a command outstanding
			assert (bg1_n || exp_addr1.size() != 0)
			else stop_with_error("master 1 holds the address grant with no command outstanding");
			assert (bg2_n || exp_addr2.size() != 0)
			else stop_with_error("master 2 holds the address grant with no command outstanding");
			// completions go first since a data grant can start in the same cycle
			check_done(1, done1, done1_addr, busy1);
			check_done(2, done2, done2_addr, busy2);
			check_data_grant(1, dbg1_n);
			check_data_grant(2, dbg2_n);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_error("timeout, the tests did not finish within the cycle budget");
	end

	initial begin
		seed = 32'h1edab528;
		arst_n = 1'b0;
		cmd1_valid = 1'b0;
		cmd1_addr = '0;
		cmd2_valid = 1'b0;
		cmd2_addr = '0;
		lock_valid = 1'b0;
		lock_addr = '0;
		// the arbiter leaves reset parked on master 1
		last_owner = owner_m1;
		lock_hold = 0;
		gap = 0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		step();

		run_round(1'b1, 1'b0);
		run_round(1'b0, 1'b1);

		// same-cycle pairs, with an occasional lone command to move the last owner
		for (int i = 0; i < 6; i++) begin
			if ($random(seed) & 1) begin
				pick = $random(seed) & 1;
				run_round(pick == 0, pick == 1);
			end
			run_round(1'b1, 1'b1);
		end

		// master 1 retries on a locked address while master 2 keeps completing
		lock_addr = 16'h5a3c;
		lock_valid = 1'b1;
		drive_cmd(1, lock_addr);
		step();
		for (int i = 0; i < 3; i++) begin
			while (busy2) begin
				step();
			end
			rand_addr = ADDR_W'($random(seed));
			if (rand_addr == lock_addr) begin
				rand_addr = ~rand_addr;
			end
			drive_cmd(2, rand_addr);
			step();
		end
		while (busy2 || exp_addr2.size() != 0) begin
			step();
		end
		assert (busy1 && exp_addr1.size() == 1)
		else stop_with_error("the locked command on master 1 finished before the lock was cleared");
		lock_valid = 1'b0;
		wait_idle();

		// random commands and gaps, a lock is only set with the bus idle
		sent = 0;
		while (sent < RANDOM_CMDS) begin
			if (lock_valid) begin
				if (lock_hold == 0) begin
					lock_valid = 1'b0;
				end else begin
					lock_hold--;
				end
			end
			if (gap != 0) begin
				gap--;
			end else if (!busy1 || !busy2) begin
				if (!busy1 && !busy2) begin
					pick = $random(seed) & 1;
				end else begin
					pick = busy1 ? 1 : 0;
				end
				rand_addr = ADDR_W'($random(seed));
				if (!lock_valid && !busy1 && !busy2 && ($random(seed) & 15) == 0) begin
					lock_valid = 1'b1;
					lock_addr = rand_addr;
					lock_hold = 16 + ($random(seed) & 15);
				end
				drive_cmd(pick + 1, rand_addr);
				sent++;
				gap = $random(seed) & 3;
			end
			step();
		end
		lock_valid = 1'b0;
		wait_idle();
		while (data_q.size() != 0 || !dbg1_n || !dbg2_n) begin
			step();
		end
		repeat (2) step();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
bus_pkg.sv
addr_arbiter.sv
bus_master.sv
snoop_responder.sv
data_arbiter.sv
bus_top.sv
tb_bus_top.sv
